// File: vlog.f
logic/ahb_sub_pkg.sv
logic/ahb_lane_decode.sv
logic/ahb_sub_ctrl.sv
logic/ahb_sub_mem.sv
logic/ahb_sub_top.sv
testbench/tb_ahb_sub.sv

// File: Bender.yml
package:
  name: ahb_sub

sources:
  # package first, then RTL in dependency order
  - logic/ahb_sub_pkg.sv
  - logic/ahb_lane_decode.sv
  - logic/ahb_sub_ctrl.sv
  - logic/ahb_sub_mem.sv
  - logic/ahb_sub_top.sv

  # testbench, top module tb_ahb_sub
  - target: test
    files:
      - testbench/tb_ahb_sub.sv

// File: testbench/tb_ahb_sub.sv
// testbench for the AHB-Lite memory subordinate
// clock and reset, pipelined bus driver, reference memory model,
// response compare process and watchdog

`timescale 1ns/1ps

module tb_ahb_sub;

  localparam int CLK_PERIOD  = 4;
  localparam int N_FILL      = ahb_sub_pkg::MEM_WORDS;
  // directed transfers rounded up
  localparam int N_DIRECT    = 40;
  localparam int N_RANDOM    = 400;
  localparam int WATCHDOG_NS = (N_FILL + N_DIRECT + N_RANDOM) * 3 * CLK_PERIOD + 200;

  // expected kind of data-phase response
  localparam int K_OKAY  = 0;
  localparam int K_READ  = 1;
  localparam int K_ERROR = 2;

  logic        HCLK;
  logic        HRESETn;
  logic        hsel;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hwrite;
  logic [2:0]  hsize;
  logic [31:0] hwdata;
  logic        hready;
  logic [31:0] hrdata;
  logic        hresp;
  logic        hreadyout;

  logic [31:0] model_mem [ahb_sub_pkg::MEM_WORDS];
  int          kind_q [$];
  logic [31:0] data_q [$];
  int          issued  = 0;
  int          checked = 0;

  // single subordinate on the bus
  assign hready = hreadyout;

  ahb_sub_top i_dut (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .hwdata    (hwdata),
    .hready    (hready),
    .hrdata    (hrdata),
    .hresp     (hresp),
    .hreadyout (hreadyout)
  );

  initial begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
  end

  // --------------------------------------------------------------------------
  // reporting
  // --------------------------------------------------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] fill_word(input int i);
    logic [7:0] b;
    b = i[7:0];
    return {b, ~b, b ^ 8'h3c, b + 8'd7};
  endfunction

  // legality, expected read word and response kind; legal writes update the model
  function automatic void ref_access(input logic sel, input logic [1:0] trans,
                                     input logic write, input logic [2:0] size,
                                     input logic [31:0] addr, input logic [31:0] wdata,
                                     output int kind, output logic [31:0] rdata);
    int   nbytes;
    int   off;
    int   idx;
    logic legal;
    kind  = K_OKAY;
    rdata = '0;
    if (sel && (trans == ahb_sub_pkg::HTRANS_NONSEQ || trans == ahb_sub_pkg::HTRANS_SEQ)) begin
      nbytes = 1 << size;
      off    = addr[1:0];
      idx    = addr[9:2];
      legal  = (addr[31:10] == '0) && (size <= 3'd2) && (off % nbytes == 0);
      if (!legal) begin
        kind = K_ERROR;
      end else if (write) begin
        // little-endian lanes starting at the byte offset
        for (int b = off; b < off + nbytes; b++) begin
          model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end else begin
        kind  = K_READ;
        rdata = model_mem[idx];
      end
    end
  endfunction

  // --------------------------------------------------------------------------
  // bus driver called on a falling edge and returning in the data phase
  // --------------------------------------------------------------------------
  task automatic issue_xfer(input logic sel, input logic [1:0] trans, input logic write,
                            input logic [2:0] size, input logic [31:0] addr,
                            input logic [31:0] wdata);
    int          kind;
    logic [31:0] rdata;
    // the manager keeps the bus IDLE during the first ERROR cycle
    while (hreadyout !== 1'b1) begin
      @(negedge HCLK);
    end
    hsel   = sel;
    htrans = trans;
    hwrite = write;
    hsize  = size;
    haddr  = addr;
    @(negedge HCLK);
    hwdata = wdata;
    hsel   = 1'b0;
    htrans = ahb_sub_pkg::HTRANS_IDLE;
    ref_access(sel, trans, write, size, addr, wdata, kind, rdata);
    kind_q.push_back(kind);
    data_q.push_back(rdata);
    issued++;
  endtask

  // --------------------------------------------------------------------------
  // compare process sampling at the edge that completes each data phase
  // --------------------------------------------------------------------------
  initial begin : compare_proc
    int          kind;
    logic [31:0] data;
    forever begin
      @(posedge HCLK);
      if (kind_q.size() > 0) begin
        kind = kind_q.pop_front();
        data = data_q.pop_front();
        if (kind == K_ERROR) begin
          if (hreadyout !== 1'b0 || hresp !== ahb_sub_pkg::HRESP_ERROR) begin
            stop_on_error("ERROR response broken: first cycle was not a wait state with ERROR");
          end
          @(posedge HCLK);
          if (hreadyout !== 1'b1 || hresp !== ahb_sub_pkg::HRESP_ERROR) begin
            stop_on_error("ERROR response broken: second cycle was not ready with ERROR");
          end
        end else begin
          check_value("hreadyout", hreadyout, 32'd1);
          check_value("hresp", hresp, ahb_sub_pkg::HRESP_OKAY);
          if (kind == K_READ) begin
            check_value("hrdata", hrdata, data);
          end
        end
        checked++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    stop_on_error("watchdog timeout: transfers did not complete in the expected time");
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  initial begin : stimulus
    int unsigned seed;
    logic [31:0] addr;
    logic [2:0]  sz;
    logic [1:0]  trans;
    logic        sel;
    int          pick;
    int          off;
    seed = 32'hfd3d_dc20;
    void'($urandom(seed));
    HRESETn = 1'b0;
    hsel    = 1'b0;
    haddr   = '0;
    htrans  = ahb_sub_pkg::HTRANS_IDLE;
    hwrite  = 1'b0;
    hsize   = ahb_sub_pkg::HSIZE_WORD;
    hwdata  = '0;
    repeat (16) @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);

    // idle bus straight after reset
    check_value("hreadyout", hreadyout, 32'd1);
    check_value("hresp", hresp, ahb_sub_pkg::HRESP_OKAY);
    check_value("hrdata", hrdata, 32'h0);

    // fill every word and read some back
    for (int i = 0; i < N_FILL; i++) begin
      issue_xfer(1'b1, ahb_sub_pkg::HTRANS_SEQ, 1'b1, ahb_sub_pkg::HSIZE_WORD, i * 4,
                 fill_word(i));
    end
    for (int i = 0; i < 8; i++) begin
      issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b0, ahb_sub_pkg::HSIZE_WORD,
                 ((i * 37) % 256) * 4, '0);
    end
    // read in the data phase of a write to the same word
    for (int i = 0; i < 4; i++) begin
      issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b1, ahb_sub_pkg::HSIZE_WORD,
                 32'h100 + i * 4, 32'h5a00_0000 + i);
      issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b0, ahb_sub_pkg::HSIZE_WORD,
                 32'h100 + i * 4, '0);
    end

    // byte and halfword lanes, word read after each write
    for (int b = 0; b < 4; b++) begin
      issue_xfer(1'b1, ahb_sub_pkg::HTRANS_SEQ, 1'b1, ahb_sub_pkg::HSIZE_BYTE, 32'h80 + b,
                 32'hc3c3_c3c3 ^ (b * 32'h1111_1111));
      issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b0, ahb_sub_pkg::HSIZE_WORD, 32'h80, '0);
    end
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b1, ahb_sub_pkg::HSIZE_HALF, 32'h80,
               32'h1357_2468);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b0, ahb_sub_pkg::HSIZE_WORD, 32'h80, '0);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_SEQ, 1'b1, ahb_sub_pkg::HSIZE_HALF, 32'h82,
               32'h9bdf_ace0);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b0, ahb_sub_pkg::HSIZE_WORD, 32'h80, '0);

    // out of range, misaligned and oversize back to back
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b1, ahb_sub_pkg::HSIZE_WORD, 32'h400,
               32'hdead_beef);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b0, ahb_sub_pkg::HSIZE_WORD, 32'h8000_0040,
               '0);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b1, ahb_sub_pkg::HSIZE_HALF, 32'h41, '1);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b1, ahb_sub_pkg::HSIZE_WORD, 32'h42, '1);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b1, 3'b011, 32'h40, '1);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b0, ahb_sub_pkg::HSIZE_WORD, 32'h0, '0);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b0, ahb_sub_pkg::HSIZE_WORD, 32'h40, '0);

    // IDLE, BUSY and deselected writes leave the word alone
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_IDLE, 1'b1, ahb_sub_pkg::HSIZE_WORD, 32'h4, '1);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_BUSY, 1'b1, ahb_sub_pkg::HSIZE_WORD, 32'h4, '1);
    issue_xfer(1'b0, ahb_sub_pkg::HTRANS_NONSEQ, 1'b1, ahb_sub_pkg::HSIZE_WORD, 32'h4, '1);
    issue_xfer(1'b1, ahb_sub_pkg::HTRANS_NONSEQ, 1'b0, ahb_sub_pkg::HSIZE_WORD, 32'h4, '0);

    // random traffic
    for (int n = 0; n < N_RANDOM; n++) begin
      pick  = $urandom % 16;
      sz    = $urandom % 3;
      off   = ($urandom % 4) & ~((1 << sz) - 1);
      addr  = {22'h0, 8'($urandom % 256), 2'(off)};
      trans = ($urandom % 2) ? ahb_sub_pkg::HTRANS_NONSEQ : ahb_sub_pkg::HTRANS_SEQ;
      sel   = 1'b1;
      case (pick)
        0: trans = ahb_sub_pkg::HTRANS_IDLE;
        1: trans = ahb_sub_pkg::HTRANS_BUSY;
        2: sel = 1'b0;
        3: addr = addr | (32'h400 << ($urandom % 22));
        4: begin
          sz      = 3'd1 + 3'($urandom % 2);
          addr[0] = 1'b1;
        end
        5: sz = 3'd3 + 3'($urandom % 5);
        default: ;
      endcase
      issue_xfer(sel, trans, 1'($urandom % 2), sz, addr, $urandom);
    end

    wait (checked == issued);
    @(negedge HCLK);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: logic/ahb_sub_top.sv
// top level of the AHB-Lite memory subordinate
// lane decoder, controller and RAM with their connecting wires

`timescale 1ns/1ps

module ahb_sub_top (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  logic                               hsel,
  input  logic [ahb_sub_pkg::ADDR_W-1:0]     haddr,
  input  logic [1:0]                         htrans,
  input  logic                               hwrite,
  input  logic [2:0]                         hsize,
  input  logic [ahb_sub_pkg::DATA_W-1:0]     hwdata,
  input  logic                               hready,
  output logic [ahb_sub_pkg::DATA_W-1:0]     hrdata,
  output logic                               hresp,
  output logic                               hreadyout
);

  ahb_sub_pkg::ahb_addr_u               haddr_u;
  logic [ahb_sub_pkg::BE_W-1:0]         lane_be;
  logic                                 size_ok;
  logic                                 rd_en;
  logic [ahb_sub_pkg::WORD_IDX_W-1:0]   wr_word;
  logic [ahb_sub_pkg::BE_W-1:0]         wr_be;

  assign haddr_u.raw = haddr;

  ahb_lane_decode i_lane_decode (
    .hsize    (hsize),
    .byte_off (haddr_u.f.byte_off),
    .lane_be  (lane_be),
    .size_ok  (size_ok)
  );

  ahb_sub_ctrl i_ctrl (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (hsel),
    .haddr     (haddr_u),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hready    (hready),
    .lane_be   (lane_be),
    .size_ok   (size_ok),
    .rd_en     (rd_en),
    .wr_word   (wr_word),
    .wr_be     (wr_be),
    .hresp     (hresp),
    .hreadyout (hreadyout)
  );

  ahb_sub_mem i_mem (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .rd_en   (rd_en),
    .rd_addr (haddr_u),
    .wr_word (wr_word),
    .wr_be   (wr_be),
    .hwdata  (hwdata),
    .hrdata  (hrdata)
  );

endmodule

// File: logic/ahb_sub_mem.sv
// word-organized RAM behind the AHB-Lite subordinate
// byte-lane writes, registered read port and forwarding of
// lanes written on the same edge as the read

`timescale 1ns/1ps

module ahb_sub_mem (
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  logic                                rd_en,
  input  ahb_sub_pkg::ahb_addr_u              rd_addr,
  input  logic [ahb_sub_pkg::WORD_IDX_W-1:0]  wr_word,
  input  logic [ahb_sub_pkg::BE_W-1:0]        wr_be,
  input  logic [ahb_sub_pkg::DATA_W-1:0]      hwdata,
  output logic [ahb_sub_pkg::DATA_W-1:0]      hrdata
);

  logic [ahb_sub_pkg::DATA_W-1:0] mem_q [ahb_sub_pkg::MEM_WORDS];
  logic [ahb_sub_pkg::DATA_W-1:0] rd_word;

  // --------------------------------------------------------------------------
  // write port
  // --------------------------------------------------------------------------
  always_ff @(posedge HCLK) begin
    for (int i = 0; i < ahb_sub_pkg::BE_W; i++) begin
      if (wr_be[i]) begin
        mem_q[wr_word][8*i +: 8] <= hwdata[8*i +: 8];
      end
    end
  end

  // --------------------------------------------------------------------------
  // read port
  // --------------------------------------------------------------------------

  // lanes being written right now win over the stored word
  always_comb begin
    rd_word = mem_q[rd_addr.f.word_idx];
    for (int i = 0; i < ahb_sub_pkg::BE_W; i++) begin
      if (wr_be[i] && (wr_word == rd_addr.f.word_idx)) begin
        rd_word[8*i +: 8] = hwdata[8*i +: 8];
      end
    end
  end

  // held until the next read
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      hrdata <= '0;
    end else if (rd_en) begin
      hrdata <= rd_word;
    end
  end

endmodule

// File: logic/ahb_sub_ctrl.sv
// control block of the AHB-Lite memory subordinate
// address-phase acceptance and legality check, read strobe,
// write lane/index registers and the two-cycle ERROR FSM

`timescale 1ns/1ps

module ahb_sub_ctrl (
  input  logic                                 HCLK,
  input  logic                                 HRESETn,
  input  logic                                 hsel,
  input  ahb_sub_pkg::ahb_addr_u               haddr,
  input  logic [1:0]                           htrans,
  input  logic                                 hwrite,
  input  logic                                 hready,
  input  logic [ahb_sub_pkg::BE_W-1:0]         lane_be,
  input  logic                                 size_ok,
  output logic                                 rd_en,
  output logic [ahb_sub_pkg::WORD_IDX_W-1:0]   wr_word,
  output logic [ahb_sub_pkg::BE_W-1:0]         wr_be,
  output logic                                 hresp,
  output logic                                 hreadyout
);

  logic [1:0]                   state_q;
  logic [1:0]                   state_d;
  logic                         trans_active;
  logic                         accept;
  logic                         legal;
  logic [ahb_sub_pkg::BE_W-1:0] wr_be_q;

  // --------------------------------------------------------------------------
  // address phase
  // --------------------------------------------------------------------------

  // IDLE and BUSY are accepted but do nothing
  always_comb begin
    case (htrans)
      ahb_sub_pkg::HTRANS_IDLE,
      ahb_sub_pkg::HTRANS_BUSY:   trans_active = 1'b0;
      ahb_sub_pkg::HTRANS_NONSEQ,
      ahb_sub_pkg::HTRANS_SEQ:    trans_active = 1'b1;
      default:                    trans_active = 1'b0;
    endcase
  end

  // no new address while the first ERROR cycle holds the bus
  assign accept = hsel & hready & hreadyout & trans_active;

  // in range and naturally aligned
  assign legal = size_ok & (haddr.f.upper == '0);

  // memory samples the word at the accepting edge
  assign rd_en = accept & legal & ~hwrite;

  // --------------------------------------------------------------------------
  // data-phase response FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ahb_sub_pkg::ST_OKAY: begin
        if (accept && !legal) begin
          state_d = ahb_sub_pkg::ST_ERR_FIRST;
        end
      end
      ahb_sub_pkg::ST_ERR_FIRST: begin
        state_d = ahb_sub_pkg::ST_ERR_SECOND;
      end
      ahb_sub_pkg::ST_ERR_SECOND: begin
        // a back-to-back illegal access restarts the sequence
        if (hready) begin
          state_d = (accept && !legal) ? ahb_sub_pkg::ST_ERR_FIRST
                                       : ahb_sub_pkg::ST_OKAY;
        end
      end
      default: begin
        state_d = ahb_sub_pkg::ST_OKAY;
      end
    endcase
  end

  assign hreadyout = (state_q != ahb_sub_pkg::ST_ERR_FIRST);
  assign hresp     = (state_q == ahb_sub_pkg::ST_OKAY) ? ahb_sub_pkg::HRESP_OKAY
                                                       : ahb_sub_pkg::HRESP_ERROR;

  // --------------------------------------------------------------------------
  // write lane and index registers
  // --------------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q <= ahb_sub_pkg::ST_OKAY;
      wr_be_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept && legal && hwrite) begin
        wr_be_q <= lane_be;
      end else if (hready) begin
        // pending write completes on this edge
        wr_be_q <= '0;
      end
    end
  end

  always_ff @(posedge HCLK) begin
    if (accept && hwrite) begin
      wr_word <= haddr.f.word_idx;
    end
  end

  // stall from another subordinate keeps the RAM from writing
  assign wr_be = wr_be_q & {ahb_sub_pkg::BE_W{hready}};

endmodule

// File: logic/ahb_lane_decode.sv
// byte-lane decoder for the AHB-Lite memory subordinate
// maps hsize and byte offset to little-endian lane enables
// and flags whether the size/alignment pair is legal

`timescale 1ns/1ps

module ahb_lane_decode (
  input  logic [2:0]                         hsize,
  input  logic [ahb_sub_pkg::BYTE_OFF_W-1:0] byte_off,
  output logic [ahb_sub_pkg::BE_W-1:0]       lane_be,
  output logic                               size_ok
);

  // purely combinational, evaluated in the address phase
  always_comb begin
    lane_be = '0;
    size_ok = 1'b0;
    case (hsize)
      ahb_sub_pkg::HSIZE_BYTE: begin
        // any offset is fine for a single byte
        lane_be[byte_off] = 1'b1;
        size_ok           = 1'b1;
      end
      ahb_sub_pkg::HSIZE_HALF: begin
        // lower or upper halfword
        lane_be[{byte_off[1], 1'b0} +: 2] = 2'b11;
        size_ok                           = ~byte_off[0];
      end
      ahb_sub_pkg::HSIZE_WORD: begin
        lane_be = '1;
        size_ok = (byte_off == '0);
      end
      default: begin
        // wider than the bus, rejected
        lane_be = '0;
        size_ok = 1'b0;
      end
    endcase
  end

  // lane_be is only consumed by the controller when size_ok is set,
  // so a misaligned halfword may still report lanes here
  // (the controller masks them through its legality check)

endmodule

// File: logic/ahb_sub_pkg.sv
// shared definitions for the AHB-Lite memory subordinate
// bus widths, memory geometry, transfer/size/response codes
// data-phase FSM state codes and the address union

package ahb_sub_pkg;

  // --------------------------------------------------------------------------
  // widths and memory geometry
  // --------------------------------------------------------------------------
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int BE_W       = DATA_W / 8;
  localparam int MEM_WORDS  = 256;
  localparam int WORD_IDX_W = $clog2(MEM_WORDS);
  localparam int BYTE_OFF_W = $clog2(BE_W);
  localparam int UPPER_W    = ADDR_W - WORD_IDX_W - BYTE_OFF_W;

  // --------------------------------------------------------------------------
  // AHB-Lite code points
  // --------------------------------------------------------------------------
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // data-phase response states
  localparam logic [1:0] ST_OKAY       = 2'd0;
  localparam logic [1:0] ST_ERR_FIRST  = 2'd1;
  localparam logic [1:0] ST_ERR_SECOND = 2'd2;

  // one bus address, seen raw or split into upper / word index / byte offset
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [UPPER_W-1:0]    upper;
      logic [WORD_IDX_W-1:0] word_idx;
      logic [BYTE_OFF_W-1:0] byte_off;
    } f;
  } ahb_addr_u;

endpackage
